/* design/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Width of a data word and of the shared bus.
`define DATA_W 32

// General registers; R0 reads as zero.
`define REG_COUNT 16

// One restoring step per quotient bit.
`define DIV_STEPS 32

`endif

/* design/isaPkg.sv */
package isaPkg;

    // Opcodes live in IR[31:27]. Any other code stops the core like HALT.
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        AND  = 5'd2,
        OR   = 5'd3,
        SHL  = 5'd4,
        SHR  = 5'd5,
        MUL  = 5'd6,
        DIV  = 5'd7,
        ADDI = 5'd8,
        MFHI = 5'd9,
        MFLO = 5'd10,
        ST   = 5'd11,
        HALT = 5'd12
    } opcodeT;

    // Instruction field positions.
    localparam int opLsb  = 27;
    localparam int opW    = 5;
    localparam int raLsb  = 23;  // Register fields are 4 bits wide.
    localparam int rbLsb  = 19;
    localparam int rcLsb  = 15;
    localparam int immLsb = 0;
    localparam int immW   = 15;  // Signed immediate.

endpackage

/* design/ctrlPkg.sv */
package ctrlPkg;

    // Micro-steps of the sequencer.
    typedef enum logic [3:0] {
        IDLE,
        T0,
        T1,
        T2,
        T3,
        T4,
        T5,
        T6,
        T7,
        HALTED
    } seqStateT;

    // Which source drives the shared bus.
    typedef enum logic [3:0] {
        NONE,
        REG,
        PC,
        MDR,
        IMM,
        ZLOW,
        ZHIGH,
        HI,
        LO
    } busSrcT;

endpackage

/* design/seqDecode.sv */
`include "cpu_defs.svh"

module seqDecode (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [`DATA_W-1:0]            bus,
    input  logic                          divDone,
    output ctrlPkg::busSrcT               busSel,
    output logic [$clog2(`REG_COUNT)-1:0] regSel,
    output logic                          pcIn,
    output logic                          marIn,
    output logic                          mdrIn,
    output logic                          irIn,
    output logic                          yIn,
    output logic                          zIn,
    output logic                          hiIn,
    output logic                          loIn,
    output logic                          regIn,
    output isaPkg::opcodeT                aluOp,
    output logic [isaPkg::immW-1:0]       imm,
    output logic                          memRead,
    output logic                          memWrite,
    output logic                          halted
);
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int selW = $clog2(`REG_COUNT);

    logic [`DATA_W-1:0] ir;
    seqStateT           state;
    seqStateT           nextState;
    opcodeT             op;
    logic [selW-1:0]    ra;
    logic [selW-1:0]    rb;
    logic [selW-1:0]    rc;
    logic               isHalt;
    logic               needT7;

    always_ff @(posedge clk) begin
        if (irIn) begin
            ir <= bus;
        end
    end

    assign op  = opcodeT'(ir[opLsb +: opW]);
    assign ra  = ir[raLsb +: selW];
    assign rb  = ir[rbLsb +: selW];
    assign rc  = ir[rcLsb +: selW];
    assign imm = ir[immLsb +: immW];

    always_comb begin
        case (op)
            ADD, SUB, AND, OR, SHL, SHR, MUL, DIV, ADDI, MFHI, MFLO, ST: isHalt = 1'b0;
            default: isHalt = 1'b1;  // Unknown codes stop the core too.
        endcase
    end

    assign needT7 = (op == MUL) || (op == DIV) || (op == ST);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            IDLE:    nextState = T0;
            T0:      nextState = T1;
            T1:      nextState = T2;
            T2:      nextState = T3;
            T3:      nextState = T4;
            T4:      nextState = isHalt ? HALTED : T5;
            T5:      nextState = divDone ? T6 : T5;  // Divider holds us here.
            T6:      nextState = needT7 ? T7 : T0;
            T7:      nextState = T0;
            default: nextState = HALTED;
        endcase
    end

    always_comb begin
        busSel   = NONE;
        regSel   = ra;
        pcIn     = 1'b0;
        marIn    = 1'b0;
        mdrIn    = 1'b0;
        irIn     = 1'b0;
        yIn      = 1'b0;
        zIn      = 1'b0;
        hiIn     = 1'b0;
        loIn     = 1'b0;
        regIn    = 1'b0;
        aluOp    = HALT;  // Non-ALU code makes the ALU increment the bus.
        memRead  = 1'b0;
        memWrite = 1'b0;
        case (state)
            T0: begin  // PC to MAR, PC + 1 into Z.
                busSel = PC;
                marIn  = 1'b1;
                zIn    = 1'b1;
            end
            T1: begin
                busSel  = ZLOW;
                pcIn    = 1'b1;
                memRead = 1'b1;
            end
            T2: mdrIn = 1'b1;  // Fetched word arrives now.
            T3: begin
                busSel = MDR;
                irIn   = 1'b1;
            end
            T4: begin
                busSel = REG;
                yIn    = 1'b1;
            end
            T5: begin
                busSel = (op == ADDI) ? IMM : REG;
                regSel = rb;
                aluOp  = op;
                zIn    = 1'b1;  // Held high so Z takes the final quotient.
            end
            T6: begin
                regSel = rc;
                case (op)
                    MFHI: begin
                        busSel = HI;
                        regIn  = 1'b1;
                    end
                    MFLO: begin
                        busSel = LO;
                        regIn  = 1'b1;
                    end
                    ST: begin  // Store address goes to MAR.
                        busSel = IMM;
                        marIn  = 1'b1;
                    end
                    MUL, DIV: begin
                        busSel = ZLOW;
                        loIn   = 1'b1;
                    end
                    default: begin
                        busSel = ZLOW;
                        regIn  = 1'b1;
                    end
                endcase
            end
            T7: begin
                if (op == ST) begin
                    busSel   = REG;
                    memWrite = 1'b1;
                end else begin
                    busSel = ZHIGH;
                    hiIn   = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign halted = (state == HALTED);

endmodule

/* design/busDatapath.sv */
`include "cpu_defs.svh"

module busDatapath (
    input  logic                          clk,
    input  logic                          rstN,
    input  ctrlPkg::busSrcT               busSel,
    input  logic [$clog2(`REG_COUNT)-1:0] regSel,
    input  logic                          pcIn,
    input  logic                          marIn,
    input  logic                          mdrIn,
    input  logic                          yIn,
    input  logic                          regIn,
    input  logic [`DATA_W-1:0]            memData,
    input  logic [`DATA_W-1:0]            zLow,
    input  logic [`DATA_W-1:0]            zHigh,
    input  logic [`DATA_W-1:0]            hi,
    input  logic [`DATA_W-1:0]            lo,
    input  logic [isaPkg::immW-1:0]       imm,
    output logic [`DATA_W-1:0]            bus,
    output logic [`DATA_W-1:0]            yVal,
    output logic [`DATA_W-1:0]            memAddr
);
    import ctrlPkg::*;

    localparam int immBits = $bits(imm);

    logic [`DATA_W-1:0] regFile [`REG_COUNT];
    logic [`DATA_W-1:0] regRead;
    logic [`DATA_W-1:0] immExt;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] mar;
    logic [`DATA_W-1:0] mdr;
    logic [`DATA_W-1:0] y;

    assign regRead = (regSel == '0) ? '0 : regFile[regSel];  // R0 is hardwired zero.
    assign immExt  = {{(`DATA_W - immBits){imm[immBits-1]}}, imm};

    always_ff @(posedge clk) begin
        if (regIn && (regSel != '0)) begin
            regFile[regSel] <= bus;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc  <= '0;  // First fetch is from address 0.
            mar <= '0;
        end else begin
            if (pcIn) begin
                pc <= bus;
            end
            if (marIn) begin
                mar <= bus;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mdrIn) begin
            mdr <= memData;
        end
        if (yIn) begin
            y <= bus;
        end
    end

    // One source at a time on the bus.
    always_comb begin
        case (busSel)
            REG:     bus = regRead;
            PC:      bus = pc;
            MDR:     bus = mdr;
            IMM:     bus = immExt;
            ZLOW:    bus = zLow;
            ZHIGH:   bus = zHigh;
            HI:      bus = hi;
            LO:      bus = lo;
            default: bus = '0;
        endcase
    end

    assign yVal    = y;
    assign memAddr = mar;

endmodule

/* design/aluExec.sv */
`include "cpu_defs.svh"

module aluExec (
    input  logic                   clk,
    input  logic                   rstN,
    input  isaPkg::opcodeT         aluOp,
    input  logic [`DATA_W-1:0]     yVal,
    input  logic [`DATA_W-1:0]     bus,
    input  logic                   zIn,
    output logic [2*`DATA_W-1:0]   result,
    output logic                   divDone
);
    import isaPkg::*;

    localparam int cntW = $clog2(`DIV_STEPS + 1);
    localparam int shW  = $clog2(`DATA_W);

    logic               divBusy;
    logic [cntW-1:0]    divCount;
    logic               divStart;
    logic               divStep;
    logic [`DATA_W-1:0] quo;  // Dividend bits shift out as quotient bits shift in.
    logic [`DATA_W-1:0] rem;
    logic [`DATA_W-1:0] divisor;
    logic               negQuo;
    logic               negRem;
    logic               divZero;
    logic [`DATA_W:0]   trial;
    logic [`DATA_W-1:0] quoOut;
    logic [`DATA_W-1:0] remOut;

    assign divStart = zIn && (aluOp == DIV) && !divBusy;
    assign divStep  = divBusy && (divCount != cntW'(`DIV_STEPS));
    assign divDone  = (aluOp != DIV) || (divBusy && (divCount == cntW'(`DIV_STEPS)));

    // Bit DATA_W of the trial difference is set when the divisor did not fit.
    assign trial = {rem, quo[`DATA_W-1]} - {1'b0, divisor};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            divBusy  <= 1'b0;
            divCount <= '0;
        end else if (divStart) begin
            divBusy  <= 1'b1;
            divCount <= '0;
        end else if (divBusy) begin
            divBusy  <= divStep;  // Drops on the done cycle.
            divCount <= divCount + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (divStart) begin  // Work on magnitudes and keep the signs aside.
            quo     <= yVal[`DATA_W-1] ? -yVal : yVal;
            divisor <= bus[`DATA_W-1] ? -bus : bus;
            rem     <= '0;
            negQuo  <= yVal[`DATA_W-1] ^ bus[`DATA_W-1];
            negRem  <= yVal[`DATA_W-1];
            divZero <= (bus == '0);
        end else if (divStep) begin
            if (!trial[`DATA_W]) begin
                rem <= trial[`DATA_W-1:0];
                quo <= {quo[`DATA_W-2:0], 1'b1};
            end else begin
                rem <= {rem[`DATA_W-2:0], quo[`DATA_W-1]};
                quo <= {quo[`DATA_W-2:0], 1'b0};
            end
        end
    end

    assign quoOut = divZero ? '1 : (negQuo ? -quo : quo);
    assign remOut = negRem ? -rem : rem;  // Remainder follows the dividend.

    always_comb begin
        case (aluOp)
            ADD, ADDI: result = {{`DATA_W{1'b0}}, yVal + bus};
            SUB:       result = {{`DATA_W{1'b0}}, yVal - bus};
            AND:       result = {{`DATA_W{1'b0}}, yVal & bus};
            OR:        result = {{`DATA_W{1'b0}}, yVal | bus};
            SHL:       result = {{`DATA_W{1'b0}}, yVal << bus[shW-1:0]};
            SHR:       result = {{`DATA_W{1'b0}}, yVal >> bus[shW-1:0]};
            MUL:       result = $signed(yVal) * $signed(bus);
            DIV:       result = {remOut, quoOut};
            default:   result = {{`DATA_W{1'b0}}, bus + `DATA_W'(1)};  // PC increment.
        endcase
    end

endmodule

/* design/resultRegs.sv */
`include "cpu_defs.svh"

module resultRegs (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 zIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  logic [2*`DATA_W-1:0] result,
    input  logic [`DATA_W-1:0]   bus,
    output logic [`DATA_W-1:0]   zLow,
    output logic [`DATA_W-1:0]   zHigh,
    output logic [`DATA_W-1:0]   hi,
    output logic [`DATA_W-1:0]   lo
);

    logic [2*`DATA_W-1:0] z;

    // Z catches the full ALU result, including the upper half of MUL and DIV.
    always_ff @(posedge clk) begin
        if (zIn) begin
            z <= result;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (hiIn) begin
                hi <= bus;  // Remainder or upper product.
            end
            if (loIn) begin
                lo <= bus;
            end
        end
    end

    assign zLow  = z[`DATA_W-1:0];
    assign zHigh = z[2*`DATA_W-1:`DATA_W];

endmodule

/* design/cpuCore.sv */
`include "cpu_defs.svh"

module cpuCore (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`DATA_W-1:0] memData,
    output logic [`DATA_W-1:0] memAddr,
    output logic               memRead,
    output logic               memWrite,
    output logic [`DATA_W-1:0] memWdata,
    output logic               halted
);
    import isaPkg::*;
    import ctrlPkg::*;

    busSrcT                        busSel;
    logic [$clog2(`REG_COUNT)-1:0] regSel;
    logic                          pcIn;
    logic                          marIn;
    logic                          mdrIn;
    logic                          irIn;
    logic                          yIn;
    logic                          zIn;
    logic                          hiIn;
    logic                          loIn;
    logic                          regIn;
    opcodeT                        aluOp;
    logic [immW-1:0]               imm;
    logic                          divDone;
    logic [`DATA_W-1:0]            bus;
    logic [`DATA_W-1:0]            yVal;
    logic [2*`DATA_W-1:0]          result;
    logic [`DATA_W-1:0]            zLow;
    logic [`DATA_W-1:0]            zHigh;
    logic [`DATA_W-1:0]            hi;
    logic [`DATA_W-1:0]            lo;

    seqDecode seq0 (
        .clk(clk), .rstN(rstN), .bus(bus), .divDone(divDone),
        .busSel(busSel), .regSel(regSel),
        .pcIn(pcIn), .marIn(marIn), .mdrIn(mdrIn), .irIn(irIn), .yIn(yIn),
        .zIn(zIn), .hiIn(hiIn), .loIn(loIn), .regIn(regIn),
        .aluOp(aluOp), .imm(imm),
        .memRead(memRead), .memWrite(memWrite), .halted(halted)
    );

    busDatapath dp0 (
        .clk(clk), .rstN(rstN), .busSel(busSel), .regSel(regSel),
        .pcIn(pcIn), .marIn(marIn), .mdrIn(mdrIn), .yIn(yIn), .regIn(regIn),
        .memData(memData), .zLow(zLow), .zHigh(zHigh), .hi(hi), .lo(lo), .imm(imm),
        .bus(bus), .yVal(yVal), .memAddr(memAddr)
    );

    aluExec alu0 (
        .clk(clk), .rstN(rstN), .aluOp(aluOp), .yVal(yVal), .bus(bus), .zIn(zIn),
        .result(result), .divDone(divDone)
    );

    resultRegs res0 (
        .clk(clk), .rstN(rstN), .zIn(zIn), .hiIn(hiIn), .loIn(loIn),
        .result(result), .bus(bus),
        .zLow(zLow), .zHigh(zHigh), .hi(hi), .lo(lo)
    );

    assign memWdata = bus;  // Stores put R[ra] on the bus.

endmodule

/* sim/cpuCore_chk.sv */
module cpuCore_chk (
    input logic clk,
    input logic rstN,
    input logic memRead,
    input logic zIn,
    input logic hiIn,
    input logic loIn,
    input logic halted
);

    int assertFails = 0;  // Number of failed assertions.

    // A fetch strobe lasts exactly one cycle.
    readPulse: assert property (@(posedge clk) disable iff (!rstN) memRead |=> !memRead)
        else begin
            assertFails++;
            $error("memRead was high for two cycles in a row");
        end

    resultLoad: assert property (@(posedge clk) disable iff (!rstN) $onehot0({zIn, hiIn, loIn}))
        else begin
            assertFails++;
            $error("more than one of the Z, HI and LO loads was high");
        end

    // Only reset leaves HALTED.
    haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
        else begin
            assertFails++;
            $error("halted fell without a reset");
        end

endmodule

bind seqDecode cpuCore_chk chk0 (
    .clk(clk), .rstN(rstN), .memRead(memRead),
    .zIn(zIn), .hiIn(hiIn), .loIn(loIn), .halted(halted)
);

/* sim/cpuCore_tb.sv */
`include "cpu_defs.svh"

module cpuCore_tb;
    import isaPkg::*;

    localparam int memWords  = 256;
    localparam int storeBase = 192;  // Stores land above the program.
    localparam int randOps   = 24;
    localparam int haltLimit = 20000;

    logic               clk = 1'b0;
    logic               rstN;
    logic [`DATA_W-1:0] memData = '0;
    logic [`DATA_W-1:0] memAddr;
    logic               memRead;
    logic               memWrite;
    logic [`DATA_W-1:0] memWdata;
    logic               halted;

    logic [`DATA_W-1:0] mem [memWords];
    logic [`DATA_W-1:0] regs [`REG_COUNT];  // Reference register file.
    logic [`DATA_W-1:0] hiModel;
    logic [`DATA_W-1:0] loModel;
    logic [`DATA_W-1:0] expAddr [$];
    logic [`DATA_W-1:0] expData [$];
    logic [7:0]         pcGen;
    integer             seed;
    int                 stAddr;
    int                 errors = 0;
    int                 checks = 0;
    int                 stores = 0;
    bit                 firstFetch = 1'b1;

    cpuCore dut0 (
        .clk(clk), .rstN(rstN), .memData(memData), .memAddr(memAddr),
        .memRead(memRead), .memWrite(memWrite), .memWdata(memWdata), .halted(halted)
    );

    always #10 clk = ~clk;

    task automatic check(input logic [`DATA_W-1:0] expVal, input logic [`DATA_W-1:0] gotVal,
                         input string msg);
        checks++;
        if (gotVal !== expVal) begin
            $display("FAIL %0t: %s, expected %h, got %h", $time, msg, expVal, gotVal);
            errors++;
        end
    endtask

    function automatic logic [`DATA_W-1:0] aluModel(input opcodeT op,
                                                    input logic [`DATA_W-1:0] a,
                                                    input logic [`DATA_W-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            SHL:     return a << b[4:0];  // Low 5 bits give the shift.
            SHR:     return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    // Writes one instruction at pcGen and steps the reference model through it.
    task automatic emit(input opcodeT op, input logic [3:0] ra, input logic [3:0] rb,
                        input logic [3:0] rc, input logic [14:0] imm);
        logic [`DATA_W-1:0] immExt;
        logic [`DATA_W-1:0] val;
        longint             a;
        longint             b;
        longint             prod;
        mem[pcGen] = {op, ra, rb, rc, imm};
        pcGen++;
        immExt = {{(`DATA_W - 15){imm[14]}}, imm};
        a      = longint'($signed(regs[ra]));
        b      = longint'($signed(regs[rb]));
        val    = regs[rc];
        case (op)
            ADDI: val = regs[ra] + immExt;
            MFHI: val = hiModel;
            MFLO: val = loModel;
            MUL: begin
                prod    = a * b;
                hiModel = prod[2*`DATA_W-1:`DATA_W];
                loModel = prod[`DATA_W-1:0];
            end
            DIV: begin
                if (b == 0) begin  // Quotient is all ones and the remainder is the dividend.
                    loModel = '1;
                    hiModel = regs[ra];
                end else begin
                    loModel = `DATA_W'(a / b);  // Truncates toward zero.
                    hiModel = `DATA_W'(a % b);
                end
            end
            ST: begin
                expAddr.push_back(immExt);
                expData.push_back(regs[ra]);
            end
            HALT: ;
            default: val = aluModel(op, regs[ra], regs[rb]);
        endcase
        if (rc != 4'd0) begin
            regs[rc] = val;
        end
    endtask

    task automatic storeReg(input logic [3:0] r);
        emit(ST, r, 4'd0, 4'd0, 15'(stAddr));
        stAddr++;
    endtask

    // MUL or DIV followed by moving both halves out through rc and storing them.
    task automatic mulDivStore(input opcodeT op, input logic [3:0] ra, input logic [3:0] rb,
                               input logic [3:0] rc);
        emit(op, ra, rb, 4'd0, 15'd0);
        emit(MFLO, 4'd0, 4'd0, rc, 15'd0);
        storeReg(rc);
        emit(MFHI, 4'd0, 4'd0, rc, 15'd0);
        storeReg(rc);
    endtask

    task automatic buildProgram();
        int         idx;
        opcodeT     op;
        logic [3:0] ra;
        logic [3:0] rb;
        logic [3:0] rc;
        pcGen   = '0;
        stAddr  = storeBase;
        hiModel = '0;
        loModel = '0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            regs[r] = '0;
        end
        for (int r = 1; r < `REG_COUNT; r++) begin
            emit(ADDI, 4'd0, 4'd0, 4'(r), 15'($random(seed)));
        end
        // Build R1 = 0x144EA4EA from pieces that fit the immediate.
        emit(ADDI, 4'd0, 4'd0, 4'd1, 15'h144E);
        emit(ADDI, 4'd0, 4'd0, 4'd2, 15'd16);
        emit(SHL, 4'd1, 4'd2, 4'd1, 15'd0);
        emit(ADDI, 4'd1, 4'd0, 4'd1, 15'h24EA);
        emit(ADDI, 4'd1, 4'd0, 4'd1, 15'h4000);
        emit(ADDI, 4'd1, 4'd0, 4'd1, 15'h4000);
        emit(ADDI, 4'd0, 4'd0, 4'd3, 15'h7F38);  // -200.
        mulDivStore(DIV, 4'd1, 4'd3, 4'd4);
        mulDivStore(MUL, 4'd1, 4'd3, 4'd5);
        mulDivStore(DIV, 4'd6, 4'd0, 4'd7);  // R0 as divisor.
        for (int n = 0; n < randOps; n++) begin
            idx = ($random(seed) & 32'h7fff_ffff) % 9;
            op  = opcodeT'(5'(idx));  // ADD through ADDI are codes 0 to 8.
            ra  = 4'($random(seed));
            rb  = 4'($random(seed));
            rc  = 4'(1 + ($random(seed) & 32'h7fff_ffff) % 15);
            if (op == MUL || op == DIV) begin
                mulDivStore(op, ra, rb, rc);
            end else begin
                emit(op, ra, rb, rc, 15'($random(seed)));
                storeReg(rc);
            end
        end
        emit(HALT, 4'd0, 4'd0, 4'd0, 15'd0);
    endtask

    // Memory answers a read on the next cycle and checks every store.
    always @(posedge clk) begin
        if (memRead) begin
            memData <= mem[memAddr[7:0]];
            if (firstFetch) begin
                check(`DATA_W'(0), memAddr, "first fetch address");
                firstFetch <= 1'b0;
            end
        end
        if (memWrite) begin
            stores++;
            if (expAddr.size() == 0) begin
                $display("Store to address %h at time %0t was not expected", memAddr, $time);
                errors++;
            end else begin
                check(expAddr.pop_front(), memAddr, "store address");
                check(expData.pop_front(), memWdata, "store data");
            end
            mem[memAddr[7:0]] <= memWdata;
        end
        if (halted && (memRead || memWrite)) begin
            $display("Memory strobe seen after halt at time %0t", $time);
            errors++;
        end
    end

    initial begin
        int cyc;
        rstN = 1'b0;
        seed = 32'h33a1_fe6a;
        for (int i = 0; i < memWords; i++) begin
            mem[8'(i)] = {HALT, 27'(i * 257)};  // Unused words decode as HALT.
        end
        buildProgram();
        @(negedge clk);
        check(`DATA_W'(0), {29'd0, memRead, memWrite, halted}, "strobes during reset");
        @(posedge clk);
        rstN <= 1'b1;
        cyc = 0;
        while (!halted && cyc < haltLimit) begin
            @(negedge clk);
            cyc++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within %0d cycles", haltLimit);
            errors++;
        end else begin
            cyc = 0;
            while (cyc < 20) begin  // Core must stay parked.
                @(negedge clk);
                check(`DATA_W'(1), {31'd0, halted}, "halted held");
                cyc++;
            end
        end
        if (expAddr.size() != 0) begin
            $display("%0d expected stores never happened", expAddr.size());
            errors++;
        end
        errors += dut0.seq0.chk0.assertFails;
        $display("Checks: %0d, stores: %0d, assertion failures: %0d, errors: %0d",
                 checks, stores, dut0.seq0.chk0.assertFails, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* cpuCore.f */
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/seqDecode.sv
design/busDatapath.sv
design/aluExec.sv
design/resultRegs.sv
design/cpuCore.sv
sim/cpuCore_chk.sv
sim/cpuCore_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = cpuCore_tb
FLIST     = cpuCore.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
